// File: design/tlb_pkg.sv
// TLB package
// Shared sizes, CP0 field positions and the enum types of the
// 16-entry joint TLB with fixed 4 KB page pairs
package tlb_pkg;

    localparam int TLB_ENTRIES = 16;
    localparam int IDX_W       = 4;
    localparam int VADDR_W     = 32;
    localparam int VPN2_W      = 19;
    localparam int ASID_W      = 8;
    localparam int PFN_W       = 20;
    localparam int CATTR_W     = 3;
    localparam int PAGE_OFS_W  = 12;
    localparam int EVEN_ODD_BIT = 12; // Odd half of the page pair

    localparam logic [CATTR_W-1:0] CACHED_ATTR = 3'd3;
    localparam int PROBE_FAIL_BIT = 31;

    // EntryHi / EntryLo layout
    localparam int ENTRYHI_VPN2_LSB = 13;
    localparam int ENTRYLO_PFN_LSB  = 6;
    localparam int ENTRYLO_C_LSB    = 3;
    localparam int ENTRYLO_D_BIT    = 2;
    localparam int ENTRYLO_V_BIT    = 1;
    localparam int ENTRYLO_G_BIT    = 0;

    typedef logic [IDX_W-1:0] tlb_idx_t;

    typedef enum logic [1:0] {
        OP_NOP,
        OP_TLBR,
        OP_TLBWI,
        OP_TLBP
    } tlb_op_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_TRANSLATE,
        ST_FETCH,
        ST_RESPOND
    } lookup_state_e;

endpackage

// File: design/tlb_entry_array.sv
// TLB entry array
// Field arrays for all entries, written by TLBWI from the CP0 words.
// Tags go out for every entry, plus two indexed combinational read
// ports, one for lookup and one for maintenance
`timescale 1ns/10ps

module tlb_entry_array (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     i_we,
    input  tlb_pkg::tlb_idx_t        i_windex,
    input  logic [31:0]              i_entryhi,
    input  logic [31:0]              i_entrylo0,
    input  logic [31:0]              i_entrylo1,
    input  tlb_pkg::tlb_idx_t        i_lk_idx,
    input  tlb_pkg::tlb_idx_t        i_rd_idx,
    output logic [tlb_pkg::TLB_ENTRIES-1:0][tlb_pkg::VPN2_W-1:0] o_tag_vpn2,
    output logic [tlb_pkg::TLB_ENTRIES-1:0][tlb_pkg::ASID_W-1:0] o_tag_asid,
    output logic [tlb_pkg::TLB_ENTRIES-1:0]                      o_tag_g,
    output logic [tlb_pkg::PFN_W-1:0]   o_lk_pfn0,
    output logic [tlb_pkg::PFN_W-1:0]   o_lk_pfn1,
    output logic [tlb_pkg::CATTR_W-1:0] o_lk_c0,
    output logic [tlb_pkg::CATTR_W-1:0] o_lk_c1,
    output logic                        o_lk_d0,
    output logic                        o_lk_d1,
    output logic                        o_lk_v0,
    output logic                        o_lk_v1,
    output logic [tlb_pkg::VPN2_W-1:0]  o_rd_vpn2,
    output logic [tlb_pkg::ASID_W-1:0]  o_rd_asid,
    output logic                        o_rd_g,
    output logic [tlb_pkg::PFN_W-1:0]   o_rd_pfn0,
    output logic [tlb_pkg::PFN_W-1:0]   o_rd_pfn1,
    output logic [tlb_pkg::CATTR_W-1:0] o_rd_c0,
    output logic [tlb_pkg::CATTR_W-1:0] o_rd_c1,
    output logic                        o_rd_d0,
    output logic                        o_rd_d1,
    output logic                        o_rd_v0,
    output logic                        o_rd_v1
);

    logic [tlb_pkg::TLB_ENTRIES-1:0][tlb_pkg::PFN_W-1:0]   pfn0_q, pfn1_q;
    logic [tlb_pkg::TLB_ENTRIES-1:0][tlb_pkg::CATTR_W-1:0] c0_q, c1_q;
    logic [tlb_pkg::TLB_ENTRIES-1:0] d0_q, d1_q, v0_q, v1_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_tag_vpn2 <= '0;
            o_tag_asid <= '0;
            o_tag_g    <= '0;
            pfn0_q     <= '0;
            pfn1_q     <= '0;
            c0_q       <= '0;
            c1_q       <= '0;
            d0_q       <= '0;
            d1_q       <= '0;
            v0_q       <= '0;
            v1_q       <= '0;
        end else if (i_we) begin
            o_tag_vpn2[i_windex] <= i_entryhi[tlb_pkg::ENTRYHI_VPN2_LSB +: tlb_pkg::VPN2_W];
            o_tag_asid[i_windex] <= i_entryhi[tlb_pkg::ASID_W-1:0];
            // Global only when both halves say so
            o_tag_g[i_windex] <= i_entrylo0[tlb_pkg::ENTRYLO_G_BIT]
                                 & i_entrylo1[tlb_pkg::ENTRYLO_G_BIT];
            pfn0_q[i_windex] <= i_entrylo0[tlb_pkg::ENTRYLO_PFN_LSB +: tlb_pkg::PFN_W];
            pfn1_q[i_windex] <= i_entrylo1[tlb_pkg::ENTRYLO_PFN_LSB +: tlb_pkg::PFN_W];
            c0_q[i_windex]   <= i_entrylo0[tlb_pkg::ENTRYLO_C_LSB +: tlb_pkg::CATTR_W];
            c1_q[i_windex]   <= i_entrylo1[tlb_pkg::ENTRYLO_C_LSB +: tlb_pkg::CATTR_W];
            d0_q[i_windex]   <= i_entrylo0[tlb_pkg::ENTRYLO_D_BIT];
            d1_q[i_windex]   <= i_entrylo1[tlb_pkg::ENTRYLO_D_BIT];
            v0_q[i_windex]   <= i_entrylo0[tlb_pkg::ENTRYLO_V_BIT];
            v1_q[i_windex]   <= i_entrylo1[tlb_pkg::ENTRYLO_V_BIT];
        end
    end

    // Lookup port
    assign o_lk_pfn0 = pfn0_q[i_lk_idx];
    assign o_lk_pfn1 = pfn1_q[i_lk_idx];
    assign o_lk_c0   = c0_q[i_lk_idx];
    assign o_lk_c1   = c1_q[i_lk_idx];
    assign o_lk_d0   = d0_q[i_lk_idx];
    assign o_lk_d1   = d1_q[i_lk_idx];
    assign o_lk_v0   = v0_q[i_lk_idx];
    assign o_lk_v1   = v1_q[i_lk_idx];

    // Maintenance port for TLBR
    assign o_rd_vpn2 = o_tag_vpn2[i_rd_idx];
    assign o_rd_asid = o_tag_asid[i_rd_idx];
    assign o_rd_g    = o_tag_g[i_rd_idx];
    assign o_rd_pfn0 = pfn0_q[i_rd_idx];
    assign o_rd_pfn1 = pfn1_q[i_rd_idx];
    assign o_rd_c0   = c0_q[i_rd_idx];
    assign o_rd_c1   = c1_q[i_rd_idx];
    assign o_rd_d0   = d0_q[i_rd_idx];
    assign o_rd_d1   = d1_q[i_rd_idx];
    assign o_rd_v0   = v0_q[i_rd_idx];
    assign o_rd_v1   = v1_q[i_rd_idx];

endmodule

// File: design/tlb_tag_match.sv
// TLB tag matcher
// Compares one VPN2/ASID pair against every entry in parallel, with
// the global bit overriding the ASID, and encodes the lowest hit
`timescale 1ns/10ps

module tlb_tag_match (
    input  logic [tlb_pkg::VPN2_W-1:0] i_vpn2,
    input  logic [tlb_pkg::ASID_W-1:0] i_asid,
    input  logic [tlb_pkg::TLB_ENTRIES-1:0][tlb_pkg::VPN2_W-1:0] i_tag_vpn2,
    input  logic [tlb_pkg::TLB_ENTRIES-1:0][tlb_pkg::ASID_W-1:0] i_tag_asid,
    input  logic [tlb_pkg::TLB_ENTRIES-1:0]                      i_tag_g,
    output logic                       o_hit,
    output tlb_pkg::tlb_idx_t          o_hit_idx
);

    logic [tlb_pkg::TLB_ENTRIES-1:0] hit_vec;

    for (genvar i = 0; i < tlb_pkg::TLB_ENTRIES; i++) begin : g_cmp
        assign hit_vec[i] = (i_tag_vpn2[i] == i_vpn2)
                            && (i_tag_g[i] || (i_tag_asid[i] == i_asid));
    end

    assign o_hit = |hit_vec;

    // Scan downward so the lowest index wins
    always_comb begin
        o_hit_idx = '0;
        for (int i = tlb_pkg::TLB_ENTRIES - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                o_hit_idx = tlb_pkg::tlb_idx_t'(i);
            end
        end
    end

endmodule

// File: design/tlb_lookup_fsm.sv
// TLB lookup FSM
// Data-side translation: locks the request, registers the hit index,
// then picks the even or odd half and forms the physical address and
// the refill / invalid / modified flags. Results hold while stalled
`timescale 1ns/10ps

module tlb_lookup_fsm (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          i_dmmu_en,
    input  logic [tlb_pkg::VADDR_W-1:0]   i_vaddr,
    input  logic                          i_store,
    input  logic                          i_stall,
    input  logic                          i_op_idle,
    input  logic [tlb_pkg::ASID_W-1:0]    i_entryhi_asid,
    input  logic                          i_hit,
    input  tlb_pkg::tlb_idx_t             i_hit_idx,
    input  logic [tlb_pkg::PFN_W-1:0]     i_lk_pfn0,
    input  logic [tlb_pkg::PFN_W-1:0]     i_lk_pfn1,
    input  logic [tlb_pkg::CATTR_W-1:0]   i_lk_c0,
    input  logic [tlb_pkg::CATTR_W-1:0]   i_lk_c1,
    input  logic                          i_lk_d0,
    input  logic                          i_lk_d1,
    input  logic                          i_lk_v0,
    input  logic                          i_lk_v1,
    output logic [tlb_pkg::VADDR_W-1:0]   o_lk_vaddr,
    output logic [tlb_pkg::ASID_W-1:0]    o_lk_asid,
    output tlb_pkg::tlb_idx_t             o_lk_idx,
    output logic                          o_rdy,
    output logic [tlb_pkg::VADDR_W-1:0]   o_paddr,
    output logic                          o_cached,
    output logic                          o_refill,
    output logic                          o_invalid,
    output logic                          o_modified
);

    tlb_pkg::lookup_state_e state_q;
    logic store_q;
    logic miss_q;
    logic accept;
    logic sel_odd;
    logic [tlb_pkg::PFN_W-1:0]   sel_pfn;
    logic [tlb_pkg::CATTR_W-1:0] sel_c;
    logic sel_d;
    logic sel_v;

    assign accept = (state_q == tlb_pkg::ST_IDLE) && i_dmmu_en && !o_rdy && i_op_idle;

    assign sel_odd = o_lk_vaddr[tlb_pkg::EVEN_ODD_BIT];
    assign sel_pfn = sel_odd ? i_lk_pfn1 : i_lk_pfn0;
    assign sel_c   = sel_odd ? i_lk_c1 : i_lk_c0;
    assign sel_d   = sel_odd ? i_lk_d1 : i_lk_d0;
    assign sel_v   = sel_odd ? i_lk_v1 : i_lk_v0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q    <= tlb_pkg::ST_IDLE;
            o_rdy      <= 1'b0;
            o_refill   <= 1'b0;
            o_invalid  <= 1'b0;
            o_modified <= 1'b0;
        end else begin
            case (state_q)
                tlb_pkg::ST_IDLE: begin
                    if (accept) state_q <= tlb_pkg::ST_TRANSLATE;
                end
                tlb_pkg::ST_TRANSLATE: state_q <= tlb_pkg::ST_FETCH;
                tlb_pkg::ST_FETCH: begin
                    state_q    <= tlb_pkg::ST_RESPOND;
                    o_rdy      <= 1'b1;
                    // Refill over invalid over modified
                    o_refill   <= miss_q;
                    o_invalid  <= !miss_q && !sel_v;
                    o_modified <= !miss_q && sel_v && store_q && !sel_d;
                end
                tlb_pkg::ST_RESPOND: begin
                    if (!i_stall) begin
                        state_q    <= tlb_pkg::ST_IDLE;
                        o_rdy      <= 1'b0;
                        o_refill   <= 1'b0;
                        o_invalid  <= 1'b0;
                        o_modified <= 1'b0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_lk_vaddr <= i_vaddr;
            o_lk_asid  <= i_entryhi_asid; // ASID locked with the address
            store_q    <= i_store;
        end
        if (state_q == tlb_pkg::ST_TRANSLATE) begin
            o_lk_idx <= i_hit_idx;
            miss_q   <= !i_hit;
        end
        if (state_q == tlb_pkg::ST_FETCH) begin
            o_paddr  <= {sel_pfn, o_lk_vaddr[tlb_pkg::PAGE_OFS_W-1:0]};
            o_cached <= (sel_c == tlb_pkg::CACHED_ATTR);
        end
    end

endmodule

// File: design/tlb_maint.sv
// TLB maintenance
// Decodes the CP0 TLB strobe. TLBWI drives the array write directly,
// TLBR and TLBP results are registered and flagged for one cycle
`timescale 1ns/10ps

module tlb_maint (
    input  logic                        clk,
    input  logic                        rst,
    input  tlb_pkg::tlb_op_e            i_tlb_op,
    input  logic                        i_probe_hit,
    input  tlb_pkg::tlb_idx_t           i_probe_idx,
    input  logic [tlb_pkg::VPN2_W-1:0]  i_rd_vpn2,
    input  logic [tlb_pkg::ASID_W-1:0]  i_rd_asid,
    input  logic                        i_rd_g,
    input  logic [tlb_pkg::PFN_W-1:0]   i_rd_pfn0,
    input  logic [tlb_pkg::PFN_W-1:0]   i_rd_pfn1,
    input  logic [tlb_pkg::CATTR_W-1:0] i_rd_c0,
    input  logic [tlb_pkg::CATTR_W-1:0] i_rd_c1,
    input  logic                        i_rd_d0,
    input  logic                        i_rd_d1,
    input  logic                        i_rd_v0,
    input  logic                        i_rd_v1,
    output logic                        o_we,
    output logic                        o_op_idle,
    output logic                        o_entry_wen,
    output logic [31:0]                 o_entryhi,
    output logic [31:0]                 o_entrylo0,
    output logic [31:0]                 o_entrylo1,
    output logic                        o_index_wen,
    output logic [31:0]                 o_index_val
);

    assign o_we      = (i_tlb_op == tlb_pkg::OP_TLBWI);
    assign o_op_idle = (i_tlb_op == tlb_pkg::OP_NOP);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_entry_wen <= 1'b0;
            o_index_wen <= 1'b0;
        end else begin
            o_entry_wen <= (i_tlb_op == tlb_pkg::OP_TLBR);
            o_index_wen <= (i_tlb_op == tlb_pkg::OP_TLBP);
        end
    end

    always_ff @(posedge clk) begin
        if (i_tlb_op == tlb_pkg::OP_TLBR) begin
            o_entryhi  <= {i_rd_vpn2, 5'b0, i_rd_asid};
            o_entrylo0 <= {6'b0, i_rd_pfn0, i_rd_c0, i_rd_d0, i_rd_v0, i_rd_g};
            o_entrylo1 <= {6'b0, i_rd_pfn1, i_rd_c1, i_rd_d1, i_rd_v1, i_rd_g};
        end
        if (i_tlb_op == tlb_pkg::OP_TLBP) begin
            if (i_probe_hit) begin
                o_index_val <= {{(32 - tlb_pkg::IDX_W){1'b0}}, i_probe_idx};
            end else begin
                o_index_val <= 32'(1) << tlb_pkg::PROBE_FAIL_BIT; // Probe miss
            end
        end
    end

endmodule

// File: design/tlb_unit.sv
// TLB unit top
// 16-entry joint TLB with one data translation port and the CP0
// TLBR, TLBWI and TLBP operations
`timescale 1ns/10ps

module tlb_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  tlb_pkg::tlb_op_e          i_tlb_op,
    input  tlb_pkg::tlb_idx_t         i_index,
    input  logic [31:0]               i_entryhi,
    input  logic [31:0]               i_entrylo0,
    input  logic [31:0]               i_entrylo1,
    input  logic                      i_dmmu_en,
    input  logic [tlb_pkg::VADDR_W-1:0] i_vaddr,
    input  logic                      i_store,
    input  logic                      i_stall,
    output logic                      o_rdy,
    output logic [tlb_pkg::VADDR_W-1:0] o_paddr,
    output logic                      o_cached,
    output logic                      o_refill,
    output logic                      o_invalid,
    output logic                      o_modified,
    output logic                      o_entry_wen,
    output logic [31:0]               o_entryhi,
    output logic [31:0]               o_entrylo0,
    output logic [31:0]               o_entrylo1,
    output logic                      o_index_wen,
    output logic [31:0]               o_index_val
);

    logic [tlb_pkg::TLB_ENTRIES-1:0][tlb_pkg::VPN2_W-1:0] tag_vpn2;
    logic [tlb_pkg::TLB_ENTRIES-1:0][tlb_pkg::ASID_W-1:0] tag_asid;
    logic [tlb_pkg::TLB_ENTRIES-1:0]                      tag_g;
    logic [tlb_pkg::PFN_W-1:0]   lk_pfn0, lk_pfn1, rd_pfn0, rd_pfn1;
    logic [tlb_pkg::CATTR_W-1:0] lk_c0, lk_c1, rd_c0, rd_c1;
    logic lk_d0, lk_d1, lk_v0, lk_v1;
    logic rd_d0, rd_d1, rd_v0, rd_v1, rd_g;
    logic [tlb_pkg::VPN2_W-1:0]  rd_vpn2;
    logic [tlb_pkg::ASID_W-1:0]  rd_asid, lk_asid;
    logic [tlb_pkg::VADDR_W-1:0] lk_vaddr;
    tlb_pkg::tlb_idx_t lk_idx, lk_hit_idx, probe_idx;
    logic lk_hit, probe_hit, we, op_idle;

    tlb_entry_array u_array (
        .clk, .rst, .i_we(we), .i_windex(i_index),
        .i_entryhi, .i_entrylo0, .i_entrylo1,
        .i_lk_idx(lk_idx), .i_rd_idx(i_index),
        .o_tag_vpn2(tag_vpn2), .o_tag_asid(tag_asid), .o_tag_g(tag_g),
        .o_lk_pfn0(lk_pfn0), .o_lk_pfn1(lk_pfn1), .o_lk_c0(lk_c0), .o_lk_c1(lk_c1),
        .o_lk_d0(lk_d0), .o_lk_d1(lk_d1), .o_lk_v0(lk_v0), .o_lk_v1(lk_v1),
        .o_rd_vpn2(rd_vpn2), .o_rd_asid(rd_asid), .o_rd_g(rd_g),
        .o_rd_pfn0(rd_pfn0), .o_rd_pfn1(rd_pfn1), .o_rd_c0(rd_c0), .o_rd_c1(rd_c1),
        .o_rd_d0(rd_d0), .o_rd_d1(rd_d1), .o_rd_v0(rd_v0), .o_rd_v1(rd_v1)
    );

    tlb_tag_match u_lookup_match (
        .i_vpn2(lk_vaddr[tlb_pkg::ENTRYHI_VPN2_LSB +: tlb_pkg::VPN2_W]),
        .i_asid(lk_asid),
        .i_tag_vpn2(tag_vpn2), .i_tag_asid(tag_asid), .i_tag_g(tag_g),
        .o_hit(lk_hit), .o_hit_idx(lk_hit_idx)
    );

    tlb_tag_match u_probe_match (
        .i_vpn2(i_entryhi[tlb_pkg::ENTRYHI_VPN2_LSB +: tlb_pkg::VPN2_W]),
        .i_asid(i_entryhi[tlb_pkg::ASID_W-1:0]),
        .i_tag_vpn2(tag_vpn2), .i_tag_asid(tag_asid), .i_tag_g(tag_g),
        .o_hit(probe_hit), .o_hit_idx(probe_idx)
    );

    tlb_lookup_fsm u_lookup (
        .clk, .rst, .i_dmmu_en, .i_vaddr, .i_store, .i_stall,
        .i_op_idle(op_idle), .i_entryhi_asid(i_entryhi[tlb_pkg::ASID_W-1:0]),
        .i_hit(lk_hit), .i_hit_idx(lk_hit_idx),
        .i_lk_pfn0(lk_pfn0), .i_lk_pfn1(lk_pfn1), .i_lk_c0(lk_c0), .i_lk_c1(lk_c1),
        .i_lk_d0(lk_d0), .i_lk_d1(lk_d1), .i_lk_v0(lk_v0), .i_lk_v1(lk_v1),
        .o_lk_vaddr(lk_vaddr), .o_lk_asid(lk_asid), .o_lk_idx(lk_idx),
        .o_rdy, .o_paddr, .o_cached, .o_refill, .o_invalid, .o_modified
    );

    tlb_maint u_maint (
        .clk, .rst, .i_tlb_op, .i_probe_hit(probe_hit), .i_probe_idx(probe_idx),
        .i_rd_vpn2(rd_vpn2), .i_rd_asid(rd_asid), .i_rd_g(rd_g),
        .i_rd_pfn0(rd_pfn0), .i_rd_pfn1(rd_pfn1), .i_rd_c0(rd_c0), .i_rd_c1(rd_c1),
        .i_rd_d0(rd_d0), .i_rd_d1(rd_d1), .i_rd_v0(rd_v0), .i_rd_v1(rd_v1),
        .o_we(we), .o_op_idle(op_idle), .o_entry_wen, .o_entryhi, .o_entrylo0,
        .o_entrylo1, .o_index_wen, .o_index_val
    );

endmodule

// File: bench/tlb_unit_properties.sv
// TLB unit properties
// Concurrent checks on the translation handshake and the CP0 result
// strobes, bound into every tlb_unit instance
`timescale 1ns/10ps

module tlb_unit_properties (
    input logic        clk,
    input logic        rst,
    input logic        i_stall,
    input logic        o_rdy,
    input logic [31:0] o_paddr,
    input logic        o_refill,
    input logic        o_invalid,
    input logic        o_modified,
    input logic        o_index_wen,
    input logic        o_entry_wen
);

    // No lookup can complete within three edges of leaving reset
    a_rdy_reset: assert property (@(posedge clk) (!rst && $past(rst, 3)) |-> !o_rdy)
        else $error("o_rdy high right after reset");

    a_index_wen_pulse: assert property (@(posedge clk) disable iff (rst)
        o_index_wen |=> !o_index_wen)
        else $error("o_index_wen high for two cycles");

    a_entry_wen_pulse: assert property (@(posedge clk) disable iff (rst)
        o_entry_wen |=> !o_entry_wen)
        else $error("o_entry_wen high for two cycles");

    a_flags_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({o_refill, o_invalid, o_modified}))
        else $error("more than one exception flag high");

    // Result frozen while the CPU stalls
    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        (o_rdy && i_stall) |=> (o_rdy && $stable(o_paddr)))
        else $error("result changed during stall");

endmodule

bind tlb_unit tlb_unit_properties u_props (
    .clk(clk), .rst(rst), .i_stall(i_stall), .o_rdy(o_rdy), .o_paddr(o_paddr),
    .o_refill(o_refill), .o_invalid(o_invalid), .o_modified(o_modified),
    .o_index_wen(o_index_wen), .o_entry_wen(o_entry_wen)
);

// File: bench/tlb_unit_tb.sv
// TLB unit testbench
// Directed tests of translation, ASID and global matching, the
// exception flags, TLBP, TLBR and the stall hold
`timescale 1ns/10ps

module tlb_unit_tb;

    localparam logic [18:0] VPN_A    = 19'h12345;
    localparam logic [18:0] VPN_B    = 19'h2a0f1;
    localparam logic [18:0] VPN_C    = 19'h0c3d7;
    localparam logic [18:0] VPN_NONE = 19'h7ffff;

    logic clk, rst;
    tlb_pkg::tlb_op_e i_tlb_op;
    tlb_pkg::tlb_idx_t i_index;
    logic [31:0] i_entryhi, i_entrylo0, i_entrylo1, i_vaddr;
    logic i_dmmu_en, i_store, i_stall;
    logic o_rdy, o_cached, o_refill, o_invalid, o_modified, o_entry_wen, o_index_wen;
    logic [31:0] o_paddr, o_entryhi, o_entrylo0, o_entrylo1, o_index_val;

    logic [31:0] rng;
    logic [19:0] pfn0, pfn1, pfn_g0, pfn_g1, pfn_c;
    int errors, test_errs, tests_run, tests_bad;
    string cur_test;

    tlb_unit uut (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] make_hi(input logic [18:0] vpn2, input logic [7:0] asid);
        return {vpn2, 5'b0, asid};
    endfunction

    function automatic logic [31:0] make_lo(input logic [19:0] pfn, input logic [2:0] c,
                                           input logic d, input logic v, input logic g);
        return {6'b0, pfn, c, d, v, g};
    endfunction

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED: %s %s expected %h actual %h", cur_test, what, exp, act);
            errors++;
            test_errs++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errs != 0) tests_bad++;
        $display("test %s: %0d errors", cur_test, test_errs);
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout: %s did not arrive in test %s", what, cur_test);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic write_entry(input int idx, input logic [31:0] hi,
                               input logic [31:0] lo0, input logic [31:0] lo1);
        @(negedge clk);
        i_tlb_op = tlb_pkg::OP_TLBWI;
        i_index = tlb_pkg::tlb_idx_t'(idx);
        i_entryhi = hi;
        i_entrylo0 = lo0;
        i_entrylo1 = lo1;
        @(negedge clk);
        i_tlb_op = tlb_pkg::OP_NOP;
    endtask

    task automatic probe(input logic [31:0] hi, output logic [31:0] idx_val);
        @(negedge clk);
        i_tlb_op = tlb_pkg::OP_TLBP;
        i_entryhi = hi;
        @(negedge clk);
        i_tlb_op = tlb_pkg::OP_NOP;
        check("index_wen pulse", 32'd1, 32'(o_index_wen));
        idx_val = o_index_val;
        @(negedge clk);
        check("index_wen single", 32'd0, 32'(o_index_wen));
    endtask

    task automatic read_entry(input int idx, output logic [31:0] hi,
                              output logic [31:0] lo0, output logic [31:0] lo1);
        @(negedge clk);
        i_tlb_op = tlb_pkg::OP_TLBR;
        i_index = tlb_pkg::tlb_idx_t'(idx);
        @(negedge clk);
        i_tlb_op = tlb_pkg::OP_NOP;
        check("entry_wen pulse", 32'd1, 32'(o_entry_wen));
        hi = o_entryhi;
        lo0 = o_entrylo0;
        lo1 = o_entrylo1;
        @(negedge clk);
        check("entry_wen single", 32'd0, 32'(o_entry_wen));
    endtask

    // Hold cycles keep i_stall high after o_rdy before releasing
    task automatic translate(input logic [31:0] va, input logic st, input logic [7:0] asid,
                             input int hold, output logic [31:0] pa, output logic ca,
                             output logic [2:0] fl);
        int cnt;
        @(negedge clk);
        i_vaddr = va;
        i_store = st;
        i_entryhi = {24'h0, asid};
        i_dmmu_en = 1'b1;
        i_stall = 1'b1;
        cnt = 0;
        do begin
            @(negedge clk);
            cnt++;
        end while (!o_rdy && cnt < 20);
        if (!o_rdy) begin
            abort_on_timeout("o_rdy");
        end else begin
            check("rdy latency", 32'd3, 32'(cnt));
            pa = o_paddr;
            ca = o_cached;
            fl = {o_refill, o_invalid, o_modified};
            repeat (hold) begin
                @(negedge clk);
                check("rdy held", 32'd1, 32'(o_rdy));
                check("paddr held", pa, o_paddr);
            end
            i_stall = 1'b0;
            i_dmmu_en = 1'b0;
            @(negedge clk);
            check("rdy cleared", 32'd0, 32'(o_rdy));
        end
    endtask

    task automatic test_translate_hit();
        logic [31:0] pa;
        logic ca;
        logic [2:0] fl;
        logic [11:0] ofs;
        start_test("translate_hit");
        rng = xorshift(rng);
        pfn0 = rng[19:0];
        rng = xorshift(rng);
        pfn1 = rng[19:0];
        write_entry(2, make_hi(VPN_A, 8'h11), make_lo(pfn0, 3'd3, 1'b1, 1'b1, 1'b0),
                    make_lo(pfn1, 3'd2, 1'b1, 1'b1, 1'b0));
        rng = xorshift(rng);
        ofs = rng[11:0];
        translate({VPN_A, 1'b0, ofs}, 1'b0, 8'h11, 0, pa, ca, fl);
        check("even paddr", {pfn0, ofs}, pa);
        check("even cached", 32'd1, 32'(ca));
        check("even flags", 32'd0, 32'(fl));
        rng = xorshift(rng);
        ofs = rng[11:0];
        translate({VPN_A, 1'b1, ofs}, 1'b1, 8'h11, 0, pa, ca, fl);
        check("odd paddr", {pfn1, ofs}, pa);
        check("odd cached", 32'd0, 32'(ca));
        check("odd flags", 32'd0, 32'(fl));
        end_test();
    endtask

    task automatic test_asid();
        logic [31:0] pa;
        logic ca;
        logic [2:0] fl;
        start_test("asid");
        translate({VPN_A, 13'h0040}, 1'b0, 8'h22, 0, pa, ca, fl);
        check("other asid refill", 32'b100, 32'(fl));
        rng = xorshift(rng);
        pfn_g0 = rng[19:0];
        rng = xorshift(rng);
        pfn_g1 = rng[19:0];
        write_entry(3, make_hi(VPN_B, 8'h33), make_lo(pfn_g0, 3'd3, 1'b1, 1'b1, 1'b1),
                    make_lo(pfn_g1, 3'd3, 1'b1, 1'b1, 1'b1));
        translate({VPN_B, 13'h1abc}, 1'b0, 8'h44, 0, pa, ca, fl);
        check("global paddr", {pfn_g1, 12'habc}, pa);
        check("global flags", 32'd0, 32'(fl));
        translate({VPN_NONE, 13'h0123}, 1'b0, 8'h11, 0, pa, ca, fl);
        check("unmapped refill", 32'b100, 32'(fl));
        end_test();
    endtask

    task automatic test_invalid_modified();
        logic [31:0] pa;
        logic ca;
        logic [2:0] fl;
        start_test("invalid_modified");
        rng = xorshift(rng);
        pfn_c = rng[19:0];
        write_entry(4, make_hi(VPN_C, 8'h11), make_lo(pfn_c, 3'd3, 1'b1, 1'b0, 1'b0),
                    make_lo(pfn_c, 3'd3, 1'b0, 1'b1, 1'b0));
        translate({VPN_C, 13'h0200}, 1'b0, 8'h11, 0, pa, ca, fl);
        check("invalid half", 32'b010, 32'(fl));
        translate({VPN_C, 13'h1200}, 1'b1, 8'h11, 0, pa, ca, fl);
        check("clean store", 32'b001, 32'(fl));
        translate({VPN_C, 13'h1345}, 1'b0, 8'h11, 0, pa, ca, fl);
        check("clean load flags", 32'd0, 32'(fl));
        check("clean load paddr", {pfn_c, 12'h345}, pa);
        end_test();
    endtask

    task automatic test_probe();
        logic [31:0] idx_val;
        start_test("probe");
        probe(make_hi(VPN_A, 8'h11), idx_val);
        check("index of A", 32'd2, idx_val);
        write_entry(6, make_hi(VPN_B, 8'h66), make_lo(20'h1, 3'd2, 1'b1, 1'b1, 1'b1),
                    make_lo(20'h2, 3'd2, 1'b1, 1'b1, 1'b1));
        probe(make_hi(VPN_B, 8'h55), idx_val);
        check("lowest of B", 32'd3, idx_val);
        probe(make_hi(VPN_NONE, 8'h11), idx_val);
        check("probe miss", 32'h8000_0000, idx_val);
        end_test();
    endtask

    task automatic test_read();
        logic [31:0] hi, lo0, lo1;
        start_test("read");
        read_entry(2, hi, lo0, lo1);
        check("entry 2 hi", make_hi(VPN_A, 8'h11), hi);
        check("entry 2 lo0", make_lo(pfn0, 3'd3, 1'b1, 1'b1, 1'b0), lo0);
        check("entry 2 lo1", make_lo(pfn1, 3'd2, 1'b1, 1'b1, 1'b0), lo1);
        read_entry(3, hi, lo0, lo1);
        check("entry 3 lo0", make_lo(pfn_g0, 3'd3, 1'b1, 1'b1, 1'b1), lo0);
        check("entry 3 lo1", make_lo(pfn_g1, 3'd3, 1'b1, 1'b1, 1'b1), lo1);
        // One G bit only, so the entry is not global
        write_entry(7, make_hi(VPN_C, 8'h77), make_lo(20'h3, 3'd2, 1'b0, 1'b1, 1'b1),
                    make_lo(20'h4, 3'd2, 1'b0, 1'b1, 1'b0));
        read_entry(7, hi, lo0, lo1);
        check("entry 7 hi", make_hi(VPN_C, 8'h77), hi);
        check("entry 7 lo0", make_lo(20'h3, 3'd2, 1'b0, 1'b1, 1'b0), lo0);
        check("entry 7 lo1", make_lo(20'h4, 3'd2, 1'b0, 1'b1, 1'b0), lo1);
        end_test();
    endtask

    task automatic test_stall_hold();
        logic [31:0] pa;
        logic ca;
        logic [2:0] fl;
        start_test("stall_hold");
        translate({VPN_A, 13'h1f0e}, 1'b0, 8'h11, 5, pa, ca, fl);
        check("stalled paddr", {pfn1, 12'hf0e}, pa);
        check("stalled flags", 32'd0, 32'(fl));
        end_test();
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        i_tlb_op = tlb_pkg::OP_NOP;
        i_index = '0;
        i_entryhi = '0;
        i_entrylo0 = '0;
        i_entrylo1 = '0;
        i_vaddr = '0;
        i_dmmu_en = 1'b0;
        i_store = 1'b0;
        i_stall = 1'b0;
        rng = 32'd39034;
        errors = 0;
        tests_run = 0;
        tests_bad = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_translate_hit();
        test_asid();
        test_invalid_modified();
        test_probe();
        test_read();
        test_stall_hold();
        $display("%0d tests run, %0d with errors, %0d check errors", tests_run, tests_bad,
                 errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
design/tlb_pkg.sv
design/tlb_entry_array.sv
design/tlb_tag_match.sv
design/tlb_lookup_fsm.sv
design/tlb_maint.sv
design/tlb_unit.sv
bench/tlb_unit_properties.sv
bench/tlb_unit_tb.sv

// File: Makefile
VERILATOR  = verilator
VFLAGS     = --timing --assert
LINT_FLAGS = --lint-only -Wall
TOP        = tlb_unit_tb
FILELIST   = vlog.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
